// ==== files.f ====
src/cpu_isa_pkg.sv
src/cpu_bus_pkg.sv
src/alu.sv
src/regfile.sv
src/fetch_bus.sv
src/decode_exec.sv
src/cpu_top.sv
verification/cpu_props.sv
verification/cpu_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the cpu testbench with verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir

verilator --binary --timing --assert -Wno-fatal --top-module cpu_tb -f files.f \
    > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/Vcpu_tb > sim.log 2>&1
cat sim.log

grep -q "Test failed" sim.log && exit 1
grep -q "Test completed successfully" sim.log && exit 0 || exit 1

// ==== src/alu.sv ====
`timescale 1ns/10ps

module alu (
    input  cpu_isa_pkg::alu_op_t op,
    input  cpu_isa_pkg::word_t   a,
    input  cpu_isa_pkg::word_t   b,
    input  cpu_isa_pkg::flags_t  cc_in,
    output cpu_isa_pkg::word_t   result,
    output cpu_isa_pkg::flags_t  cc_out
);

    // extra bit holds carry out or borrow
    logic [16:0] sum;
    logic [16:0] diff;

    assign sum  = {1'b0, a} + {1'b0, b};
    assign diff = {1'b0, a} - {1'b0, b};

    always_comb begin
        // c and v pass through unless add or sub
        cc_out = cc_in;
        case (op)
            cpu_isa_pkg::ALU_ADD: begin
                result   = sum[15:0];
                cc_out.c = sum[16];
                // same operand signs, result sign flipped
                cc_out.v = (a[15] == b[15]) && (sum[15] != a[15]);
            end
            cpu_isa_pkg::ALU_SUB: begin
                result   = diff[15:0];
                // carry set means no borrow
                cc_out.c = ~diff[16];
                cc_out.v = (a[15] != b[15]) && (diff[15] != a[15]);
            end
            cpu_isa_pkg::ALU_AND: result = a & b;
            cpu_isa_pkg::ALU_OR:  result = a | b;
            cpu_isa_pkg::ALU_XOR: result = a ^ b;
            cpu_isa_pkg::ALU_MOV: result = b;
            // shift amount from the low nibble only
            cpu_isa_pkg::ALU_LSL: result = a << b[3:0];
            cpu_isa_pkg::ALU_LSR: result = a >> b[3:0];
            // reserved codes, result is never written back
            default: result = '0;
        endcase
        cc_out.n = result[15];
        cc_out.z = result == '0;
    end

endmodule

// ==== src/cpu_bus_pkg.sv ====
package cpu_bus_pkg;

    // shared memory bus, rdata comes back one cycle after re
    typedef struct packed {
        cpu_isa_pkg::word_t addr;
        cpu_isa_pkg::word_t wdata;
        logic               re;
        logic               we;
    } mem_req_t;

    // word handed from fetch to stage two
    // pc is the fetch address register in the same cycle
    typedef struct packed {
        cpu_isa_pkg::instr_t instr;
        logic                valid;
        cpu_isa_pkg::word_t  pc;
    } fetch_word_t;

    // control back from stage two to fetch
    typedef struct packed {
        logic               take_branch;
        logic               stall;
        cpu_isa_pkg::word_t target;
    } redirect_t;

    // load or store wanted by stage two, granted the same cycle
    typedef struct packed {
        logic               load;
        logic               store;
        cpu_isa_pkg::word_t addr;
        cpu_isa_pkg::word_t wdata;
    } data_req_t;

endpackage

// ==== src/cpu_isa_pkg.sv ====
package cpu_isa_pkg;

    // data and address word
    typedef logic [15:0] word_t;

    // register index, r0..r7
    typedef logic [2:0] reg_idx_t;

    // alu operation, taken from op[3:0] of alu instructions
    // codes 8..11 are reserved and decode as no-ops
    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR  = 4'd3,
        ALU_XOR = 4'd4,
        ALU_MOV = 4'd5,
        ALU_LSL = 4'd6,
        ALU_LSR = 4'd7
    } alu_op_t;

    // short branch conditions, bits 13..10 of a branch word
    typedef enum logic [3:0] {
        COND_EQ, COND_NE, COND_CS, COND_CC,
        COND_MI, COND_PL, COND_VS, COND_VC,
        COND_HI, COND_LS, COND_GE, COND_LT,
        COND_GT, COND_LE, COND_AL, COND_NV
    } cond_t;

    // condition codes, n in the msb
    typedef struct packed {
        logic n;
        logic z;
        logic c;
        logic v;
    } flags_t;

    // instruction word, op in the top five bits
    // low four bits are the signed immediate when mode is 0x
    typedef struct packed {
        logic [4:0] op;
        reg_idx_t   rd;
        reg_idx_t   ra;
        logic [1:0] mode;
        logic [2:0] rb_imm;
    } instr_t;

    localparam logic [4:0] OP_LOAD  = 5'b01100;
    localparam logic [4:0] OP_STORE = 5'b01101;

endpackage

// ==== src/cpu_top.sv ====
`timescale 1ns/10ps

module cpu_top #(
    parameter cpu_isa_pkg::word_t RESET_PC = '0
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  halt,
    input  cpu_isa_pkg::word_t    rdata,
    output cpu_bus_pkg::mem_req_t mem
);

    // stage one <-> stage two
    cpu_bus_pkg::fetch_word_t fetch_word;
    cpu_bus_pkg::redirect_t   redirect;
    cpu_bus_pkg::data_req_t   data_req;

    // register file ports
    cpu_isa_pkg::reg_idx_t raddr_a;
    cpu_isa_pkg::reg_idx_t raddr_b;
    cpu_isa_pkg::reg_idx_t raddr_d;
    cpu_isa_pkg::word_t    rdata_a;
    cpu_isa_pkg::word_t    rdata_b;
    cpu_isa_pkg::word_t    rdata_d;
    logic                  rf_we;
    cpu_isa_pkg::reg_idx_t rf_waddr;
    cpu_isa_pkg::word_t    rf_wdata;

    // alu ports
    cpu_isa_pkg::alu_op_t alu_op;
    cpu_isa_pkg::word_t   alu_a;
    cpu_isa_pkg::word_t   alu_b;
    cpu_isa_pkg::word_t   alu_result;
    cpu_isa_pkg::flags_t  alu_flags;
    cpu_isa_pkg::flags_t  flags;

    fetch_bus #(.RESET_PC(RESET_PC)) u_fetch (
        .clk(clk), .rst(rst), .halt(halt), .rdata(rdata),
        .redirect(redirect), .data_req(data_req),
        .fetch(fetch_word), .mem(mem)
    );

    decode_exec u_exec (
        .clk(clk), .rst(rst), .halt(halt), .fetch(fetch_word), .rdata(rdata),
        .rdata_a(rdata_a), .rdata_b(rdata_b), .rdata_d(rdata_d),
        .alu_result(alu_result), .alu_flags(alu_flags),
        .redirect(redirect), .data_req(data_req),
        .raddr_a(raddr_a), .raddr_b(raddr_b), .raddr_d(raddr_d),
        .we(rf_we), .waddr(rf_waddr), .wdata(rf_wdata),
        .alu_op(alu_op), .alu_a(alu_a), .alu_b(alu_b), .flags(flags)
    );

    regfile u_regs (
        .clk(clk), .rst(rst),
        .raddr_a(raddr_a), .raddr_b(raddr_b), .raddr_c(raddr_d),
        .we(rf_we), .waddr(rf_waddr), .wdata(rf_wdata),
        .rdata_a(rdata_a), .rdata_b(rdata_b), .rdata_c(rdata_d)
    );

    alu u_alu (
        .op(alu_op), .a(alu_a), .b(alu_b), .cc_in(flags),
        .result(alu_result), .cc_out(alu_flags)
    );

endmodule

// ==== src/decode_exec.sv ====
`timescale 1ns/10ps

module decode_exec (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     halt,
    input  cpu_bus_pkg::fetch_word_t fetch,
    input  cpu_isa_pkg::word_t       rdata,
    input  cpu_isa_pkg::word_t       rdata_a,
    input  cpu_isa_pkg::word_t       rdata_b,
    input  cpu_isa_pkg::word_t       rdata_d,
    input  cpu_isa_pkg::word_t       alu_result,
    input  cpu_isa_pkg::flags_t      alu_flags,
    output cpu_bus_pkg::redirect_t   redirect,
    output cpu_bus_pkg::data_req_t   data_req,
    output cpu_isa_pkg::reg_idx_t    raddr_a,
    output cpu_isa_pkg::reg_idx_t    raddr_b,
    output cpu_isa_pkg::reg_idx_t    raddr_d,
    output logic                     we,
    output cpu_isa_pkg::reg_idx_t    waddr,
    output cpu_isa_pkg::word_t       wdata,
    output cpu_isa_pkg::alu_op_t     alu_op,
    output cpu_isa_pkg::word_t       alu_a,
    output cpu_isa_pkg::word_t       alu_b,
    output cpu_isa_pkg::flags_t      flags
);

    typedef enum logic [1:0] {
        DECODE,
        LS1,
        LS2,
        BRANCH_DELAY
    } state_t;

    state_t               state;
    state_t               state_next;
    cpu_isa_pkg::instr_t  ir;
    cpu_isa_pkg::word_t   ir_bits;
    cpu_isa_pkg::flags_t  flags_next;

    // decoded fields
    logic                 is_alu;
    logic                 is_ls;
    logic                 is_load;
    logic                 is_store;
    logic                 is_branch;
    logic                 operand_ok;
    logic [3:0]           imm4;
    cpu_isa_pkg::cond_t   br_cond;
    cpu_isa_pkg::word_t   br_offset;
    logic                 cond_true;

    // sequencer outputs before halt gating
    logic                 take;
    logic                 stall;
    logic                 do_wb;
    logic                 ld;
    logic                 st;
    cpu_isa_pkg::word_t   wb_val;

    assign ir_bits = ir;

    // 010xx alu codes are reserved, only 00xxx executes
    assign is_alu     = ir.op[4:3] == 2'b00;
    assign is_load    = ir.op == cpu_isa_pkg::OP_LOAD;
    assign is_store   = ir.op == cpu_isa_pkg::OP_STORE;
    assign is_ls      = is_load | is_store;
    assign is_branch  = ir.op[4:3] == 2'b10;
    // mode 11 no longer supported
    assign operand_ok = ir.mode != 2'b11;
    assign imm4       = {ir.mode[0], ir.rb_imm};

    // branch view of the same word
    assign br_cond   = cpu_isa_pkg::cond_t'(ir_bits[13:10]);
    assign br_offset = {{6{ir_bits[9]}}, ir_bits[9:0]};

    // operands
    assign raddr_a = ir.ra;
    assign raddr_b = ir.rb_imm;
    assign raddr_d = ir.rd;
    assign alu_a   = rdata_a;
    assign alu_b   = ir.mode[1] ? rdata_b : {{12{imm4[3]}}, imm4};
    // loads and stores use the adder for ra + operand
    assign alu_op  = is_ls ? cpu_isa_pkg::ALU_ADD : cpu_isa_pkg::alu_op_t'(ir.op[3:0]);

    // condition table
    always_comb begin
        cond_true = 1'b0;
        case (br_cond)
            cpu_isa_pkg::COND_EQ: cond_true = flags.z;
            cpu_isa_pkg::COND_NE: cond_true = !flags.z;
            cpu_isa_pkg::COND_CS: cond_true = flags.c;
            cpu_isa_pkg::COND_CC: cond_true = !flags.c;
            cpu_isa_pkg::COND_MI: cond_true = flags.n;
            cpu_isa_pkg::COND_PL: cond_true = !flags.n;
            cpu_isa_pkg::COND_VS: cond_true = flags.v;
            cpu_isa_pkg::COND_VC: cond_true = !flags.v;
            cpu_isa_pkg::COND_HI: cond_true = flags.c && !flags.z;
            cpu_isa_pkg::COND_LS: cond_true = !flags.c || flags.z;
            cpu_isa_pkg::COND_GE: cond_true = flags.n == flags.v;
            cpu_isa_pkg::COND_LT: cond_true = flags.n != flags.v;
            cpu_isa_pkg::COND_GT: cond_true = !flags.z && (flags.n == flags.v);
            cpu_isa_pkg::COND_LE: cond_true = flags.z || (flags.n != flags.v);
            cpu_isa_pkg::COND_AL: cond_true = 1'b1;
            cpu_isa_pkg::COND_NV: cond_true = 1'b0;
        endcase
    end

    // sequencer
    always_comb begin
        state_next = state;
        flags_next = flags;
        take       = 1'b0;
        stall      = 1'b0;
        do_wb      = 1'b0;
        ld         = 1'b0;
        st         = 1'b0;
        wb_val     = alu_result;
        case (state)
            DECODE: begin
                if (is_branch) begin
                    take = cond_true;
                    // one delay cycle drops the word already in flight
                    if (cond_true) begin
                        state_next = BRANCH_DELAY;
                    end
                end else if (is_alu && operand_ok) begin
                    do_wb      = 1'b1;
                    flags_next = alu_flags;
                end else if (is_ls && operand_ok) begin
                    ld         = is_load & ~halt;
                    st         = is_store & ~halt;
                    stall      = 1'b1;
                    state_next = LS1;
                end
                // anything else falls through as a no-op
            end
            LS1: begin
                // load data is on rdata now
                stall      = 1'b1;
                do_wb      = is_load;
                wb_val     = rdata;
                // keep the read going while frozen so the data is still there
                ld         = is_load & halt;
                state_next = LS2;
            end
            LS2: begin
                // fetch catches up
                state_next = DECODE;
            end
            BRANCH_DELAY: begin
                state_next = DECODE;
            end
        endcase
    end

    assign redirect = '{take_branch: take, stall: stall, target: fetch.pc + br_offset};
    assign data_req = '{load: ld, store: st, addr: alu_result, wdata: rdata_d};

    // writeback
    assign we    = do_wb & ~halt;
    assign waddr = ir.rd;
    assign wdata = wb_val;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= DECODE;
            ir    <= '0;
            flags <= '0;
        end else if (!halt) begin
            state <= state_next;
            flags <= flags_next;
            // invalid word becomes add r0, r0, #0
            if (state_next == DECODE) begin
                ir <= fetch.valid ? fetch.instr : '0;
            end
        end
    end

endmodule

// ==== src/fetch_bus.sv ====
`timescale 1ns/10ps

module fetch_bus #(
    parameter cpu_isa_pkg::word_t RESET_PC = '0
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     halt,
    input  cpu_isa_pkg::word_t       rdata,
    input  cpu_bus_pkg::redirect_t   redirect,
    input  cpu_bus_pkg::data_req_t   data_req,
    output cpu_bus_pkg::fetch_word_t fetch,
    output cpu_bus_pkg::mem_req_t    mem
);

    cpu_isa_pkg::word_t pc;
    cpu_isa_pkg::word_t pc_next;
    // low for the first cycle after reset, no fetch yet
    logic fetch_en;
    // bus carried a fetch last cycle
    logic fetch_valid;
    logic data_cycle;

    assign data_cycle = data_req.load | data_req.store;

    // next fetch address
    always_comb begin
        if (!fetch_en || halt || redirect.stall) begin
            pc_next = pc;
        end else if (redirect.take_branch) begin
            pc_next = redirect.target;
        end else begin
            pc_next = pc + 16'd1;
        end
    end

    // data access wins the bus over the fetch
    always_comb begin
        mem.wdata = data_req.wdata;
        mem.we    = data_req.store;
        if (data_cycle) begin
            mem.addr = data_req.addr;
            mem.re   = data_req.load;
        end else begin
            mem.addr = pc_next;
            mem.re   = fetch_en;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            // one below so the first increment lands on RESET_PC
            pc          <= RESET_PC - 16'd1;
            fetch_en    <= 1'b0;
            fetch_valid <= 1'b0;
        end else begin
            pc          <= pc_next;
            fetch_en    <= 1'b1;
            fetch_valid <= fetch_en & ~data_cycle;
        end
    end

    // returning word is the instruction, no extra register
    assign fetch = '{instr: cpu_isa_pkg::instr_t'(rdata), valid: fetch_valid, pc: pc};

endmodule

// ==== src/regfile.sv ====
`timescale 1ns/10ps

module regfile (
    input  logic                  clk,
    input  logic                  rst,
    input  cpu_isa_pkg::reg_idx_t raddr_a,
    input  cpu_isa_pkg::reg_idx_t raddr_b,
    input  cpu_isa_pkg::reg_idx_t raddr_c,
    input  logic                  we,
    input  cpu_isa_pkg::reg_idx_t waddr,
    input  cpu_isa_pkg::word_t    wdata,
    output cpu_isa_pkg::word_t    rdata_a,
    output cpu_isa_pkg::word_t    rdata_b,
    output cpu_isa_pkg::word_t    rdata_c
);

    // r0..r7, r0 is an ordinary register
    cpu_isa_pkg::word_t regs [0:7];

    // asynchronous reads
    assign rdata_a = regs[raddr_a];
    assign rdata_b = regs[raddr_b];
    assign rdata_c = regs[raddr_c];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[waddr] <= wdata;
        end
    end

endmodule

// ==== verification/cpu_props.sv ====
`timescale 1ns/10ps

module cpu_props (
    input logic                  clk,
    input logic                  rst,
    input cpu_bus_pkg::mem_req_t mem
);

    // rst seen on the previous edge too, so the dut has reset
    logic rst_q;

    initial rst_q = 1'b0;

    always @(posedge clk) begin
        rst_q <= rst;
    end

    // one access per cycle
    assert property (@(posedge clk) !(mem.re && mem.we))
        else $error("read and write strobes high together");

    // bus idle while in reset
    assert property (@(posedge clk) (rst && rst_q) |-> (!mem.re && !mem.we))
        else $error("bus strobe high during reset");

    // store occupies three cycles, only the first writes
    assert property (@(posedge clk) disable iff (rst) mem.we |=> !mem.we)
        else $error("write strobe one cycle after a store");
    assert property (@(posedge clk) disable iff (rst) $past(mem.we, 2) |-> !mem.we)
        else $error("write strobe two cycles after a store");

endmodule

bind cpu_top cpu_props u_props (.clk(clk), .rst(rst), .mem(mem));

// ==== verification/cpu_tb.sv ====
`timescale 1ns/10ps

module cpu_tb;

    localparam cpu_isa_pkg::word_t RESET_PC = 16'h0010;
    localparam int CLK_PERIOD = 8;
    localparam int TEST_COUNT = 5;
    localparam int CYCLES_PER_TEST = 400;

    logic                  clk;
    logic                  rst;
    logic                  halt;
    cpu_isa_pkg::word_t    rdata;
    cpu_bus_pkg::mem_req_t mem;

    // memory model and store log
    logic [15:0] memory [0:255];
    logic [7:0]  rd_addr;
    logic [7:0]  prog_ptr;
    logic [15:0] log_addr [$];
    logic [15:0] log_data [$];
    logic        done;
    logic        first_seen;
    logic [15:0] first_addr;
    logic        halt_seen;
    logic [15:0] halt_addr;
    int          errors;
    int          seed;

    cpu_top #(.RESET_PC(RESET_PC)) UUT (
        .clk(clk), .rst(rst), .halt(halt), .rdata(rdata), .mem(mem)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // bus is sampled on the rising edge, before the dut settles again
    always @(posedge clk) begin
        if (rst) begin
            first_seen = 1'b0;
        end else if (mem.re && !first_seen) begin
            first_seen = 1'b1;
            first_addr = mem.addr;
        end
        if (mem.re) begin
            rd_addr = mem.addr[7:0];
        end
        if (mem.we) begin
            memory[mem.addr[7:0]] = mem.wdata;
            log_addr.push_back(mem.addr);
            log_data.push_back(mem.wdata);
            // end-of-program marker
            if (mem.addr == 16'h00FF) begin
                done = 1'b1;
            end
        end
        if (halt) begin
            if (mem.we) begin
                errors++;
                $display("store issued while halted at address %h", mem.addr);
            end
            if (halt_seen) begin
                check_value("mem.addr while halted", mem.addr, halt_addr);
            end
            halt_addr = mem.addr;
            halt_seen = 1'b1;
        end else begin
            halt_seen = 1'b0;
        end
    end

    // read data lands in the cycle after re
    always @(negedge clk) begin
        rdata <= memory[rd_addr];
    end

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
        if (got !== exp) begin
            errors++;
            $display("mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    // instruction encoders
    function automatic logic [15:0] enc_imm(input logic [4:0] op, input logic [2:0] rd,
                                            input logic [2:0] ra, input logic [3:0] imm);
        return {op, rd, ra, 1'b0, imm};
    endfunction

    function automatic logic [15:0] enc_reg(input logic [4:0] op, input logic [2:0] rd,
                                            input logic [2:0] ra, input logic [2:0] rb);
        return {op, rd, ra, 2'b10, rb};
    endfunction

    function automatic logic [15:0] enc_branch(input logic [3:0] cond, input logic [9:0] off);
        return {2'b10, cond, off};
    endfunction

    // reference alu result, shifts by the low nibble of b
    function automatic logic [15:0] expect_alu(input int op, input logic [15:0] a,
                                               input logic [15:0] b);
        case (op)
            0: return a + b;
            1: return a - b;
            2: return a & b;
            3: return a | b;
            4: return a ^ b;
            5: return b;
            6: return a << b[3:0];
            default: return a >> b[3:0];
        endcase
    endfunction

    // condition outcome after sub a, b
    function automatic logic cond_holds(input int cond, input logic [15:0] a,
                                        input logic [15:0] b);
        logic [15:0] d;
        logic        n;
        logic        z;
        logic        c;
        logic        v;
        int          sd;
        d  = a - b;
        n  = d[15];
        z  = a == b;
        c  = a >= b;
        sd = int'($signed(a)) - int'($signed(b));
        v  = sd > 32767 || sd < -32768;
        case (cond)
            0: return z;
            1: return !z;
            2: return c;
            3: return !c;
            4: return n;
            5: return !n;
            6: return v;
            7: return !v;
            8: return c && !z;
            9: return !c || z;
            10: return n == v;
            11: return n != v;
            12: return !z && n == v;
            13: return z || n != v;
            14: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    task automatic emit_word(input logic [15:0] w);
        memory[prog_ptr] = w;
        prog_ptr++;
    endtask

    // reset, fresh memory, then the common base registers
    task automatic begin_test;
        @(negedge clk);
        rst  = 1'b1;
        halt = 1'b0;
        done = 1'b0;
        log_addr.delete();
        log_data.delete();
        for (int i = 0; i < 256; i++) begin
            memory[i] = {i[7:0], ~i[7:0]};
        end
        prog_ptr = RESET_PC[7:0];
        // r7 = 0xc0 data, r6 = 0xff end marker, r5 = 0xd0 and r4 = 0xd8 results
        emit_word(enc_imm({1'b0, cpu_isa_pkg::ALU_MOV}, 3'd7, 3'd0, 4'd3));
        emit_word(enc_imm({1'b0, cpu_isa_pkg::ALU_LSL}, 3'd7, 3'd7, 4'd6));
        emit_word(enc_imm({1'b0, cpu_isa_pkg::ALU_MOV}, 3'd6, 3'd0, 4'hF));
        emit_word(enc_imm({1'b0, cpu_isa_pkg::ALU_LSR}, 3'd6, 3'd6, 4'd4));
        emit_word(enc_imm({1'b0, cpu_isa_pkg::ALU_LSR}, 3'd6, 3'd6, 4'd4));
        emit_word(enc_imm({1'b0, cpu_isa_pkg::ALU_MOV}, 3'd5, 3'd0, 4'd1));
        emit_word(enc_imm({1'b0, cpu_isa_pkg::ALU_LSL}, 3'd5, 3'd5, 4'd4));
        emit_word(enc_reg({1'b0, cpu_isa_pkg::ALU_OR}, 3'd5, 3'd5, 3'd7));
        emit_word(enc_imm({1'b0, cpu_isa_pkg::ALU_ADD}, 3'd4, 3'd5, 4'd7));
        emit_word(enc_imm({1'b0, cpu_isa_pkg::ALU_ADD}, 3'd4, 3'd4, 4'd1));
    endtask

    // store to 0xff, then spin on a branch to itself
    task automatic emit_end;
        emit_word(enc_imm(cpu_isa_pkg::OP_STORE, 3'd0, 3'd6, 4'd0));
        emit_word(enc_branch(cpu_isa_pkg::COND_AL, 10'h3FF));
    endtask

    task automatic run_program;
        for (int i = 0; i < 4; i++) begin
            @(posedge clk);
            if (i > 0) begin
                check_value("mem.re in reset", {15'd0, mem.re}, 16'd0);
                check_value("mem.we in reset", {15'd0, mem.we}, 16'd0);
            end
        end
        @(negedge clk);
        rst = 1'b0;
        wait (done);
        check_value("first read addr", first_addr, RESET_PC);
        @(negedge clk);
    endtask

    task automatic find_store(input logic [15:0] addr, output logic found,
                              output logic [15:0] data);
        found = 1'b0;
        data  = '0;
        foreach (log_addr[k]) begin
            if (log_addr[k] == addr) begin
                found = 1'b1;
                data  = log_data[k];
            end
        end
    endtask

    task automatic expect_store(input string name, input logic [15:0] addr,
                                input logic [15:0] exp);
        logic        found;
        logic [15:0] data;
        find_store(addr, found, data);
        if (!found) begin
            errors++;
            $display("no store was seen at address %h for %s", addr, name);
        end else begin
            check_value(name, data, exp);
        end
    endtask

    // one branch per condition, each skipping a marker store
    task automatic emit_probe;
        for (int c = 0; c < 16; c++) begin
            emit_word(enc_branch(4'(c), 10'd1));
            emit_word(enc_imm(cpu_isa_pkg::OP_STORE, 3'd6, (c < 8) ? 3'd5 : 3'd4, 4'(c % 8)));
        end
    endtask

    task automatic check_probe(input logic [15:0] a, input logic [15:0] b);
        logic        found;
        logic [15:0] data;
        for (int c = 0; c < 16; c++) begin
            find_store(16'hD0 + 16'(c), found, data);
            check_value($sformatf("marker cond %0d", c), {15'd0, found},
                        {15'd0, !cond_holds(c, a, b)});
            if (found) begin
                check_value($sformatf("marker value cond %0d", c), data, 16'h00FF);
            end
        end
    endtask

    // operands at 0xc0 and 0xc1 into r1 and r2
    task automatic emit_operand_loads;
        emit_word(enc_imm(cpu_isa_pkg::OP_LOAD, 3'd1, 3'd7, 4'd0));
        emit_word(enc_imm(cpu_isa_pkg::OP_LOAD, 3'd2, 3'd7, 4'd1));
    endtask

    task automatic test_alu;
        logic [15:0] a;
        logic [15:0] b;
        a = 16'($random(seed));
        b = 16'($random(seed));
        begin_test;
        memory[8'hC0] = a;
        memory[8'hC1] = b;
        emit_operand_loads;
        for (int op = 0; op < 8; op++) begin
            emit_word(enc_reg(5'(op), 3'd3, 3'd1, 3'd2));
            emit_word(enc_imm(cpu_isa_pkg::OP_STORE, 3'd3, 3'd5, 4'(op)));
        end
        // immediate operand, -3
        emit_word(enc_imm({1'b0, cpu_isa_pkg::ALU_ADD}, 3'd3, 3'd1, 4'hD));
        emit_word(enc_imm(cpu_isa_pkg::OP_STORE, 3'd3, 3'd4, 4'd0));
        emit_end;
        run_program;
        for (int op = 0; op < 8; op++) begin
            expect_store($sformatf("alu op %0d", op), 16'hD0 + 16'(op), expect_alu(op, a, b));
        end
        expect_store("alu immediate", 16'hD8, a - 16'd3);
    endtask

    task automatic test_branches;
        logic [15:0] a_list [4];
        logic [15:0] b_list [4];
        // equal, signed overflow, borrow, random
        a_list = '{16'h0005, 16'h8000, 16'h0001, 16'($random(seed))};
        b_list = '{16'h0005, 16'h0001, 16'h0002, 16'($random(seed))};
        for (int p = 0; p < 4; p++) begin
            begin_test;
            memory[8'hC0] = a_list[p];
            memory[8'hC1] = b_list[p];
            emit_operand_loads;
            emit_word(enc_reg({1'b0, cpu_isa_pkg::ALU_SUB}, 3'd3, 3'd1, 3'd2));
            emit_probe;
            emit_end;
            run_program;
            check_probe(a_list[p], b_list[p]);
        end
    endtask

    task automatic test_load_store;
        logic [15:0] w [4];
        begin_test;
        for (int i = 0; i < 4; i++) begin
            w[i] = 16'($random(seed));
            memory[8'hC0 + 8'(i)] = w[i];
        end
        emit_word(enc_imm({1'b0, cpu_isa_pkg::ALU_MOV}, 3'd4, 3'd0, 4'd3));
        emit_word(enc_imm(cpu_isa_pkg::OP_LOAD, 3'd1, 3'd7, 4'd0));
        emit_word(enc_imm(cpu_isa_pkg::OP_STORE, 3'd1, 3'd5, 4'd0));
        emit_word(enc_imm(cpu_isa_pkg::OP_LOAD, 3'd2, 3'd7, 4'd1));
        emit_word(enc_reg(cpu_isa_pkg::OP_STORE, 3'd2, 3'd5, 3'd4));
        emit_word(enc_reg(cpu_isa_pkg::OP_LOAD, 3'd3, 3'd7, 3'd4));
        // negative immediate offset
        emit_word(enc_imm(cpu_isa_pkg::OP_STORE, 3'd3, 3'd5, 4'hF));
        emit_word(enc_imm(cpu_isa_pkg::OP_LOAD, 3'd1, 3'd7, 4'd2));
        emit_word(enc_imm(cpu_isa_pkg::OP_STORE, 3'd1, 3'd5, 4'd7));
        emit_end;
        run_program;
        expect_store("copy imm offset", 16'hD0, w[0]);
        expect_store("copy reg offset", 16'hD3, w[1]);
        expect_store("copy neg offset", 16'hCF, w[3]);
        expect_store("copy max offset", 16'hD7, w[2]);
    endtask

    task automatic emit_halt_program(input logic [15:0] w0, input logic [15:0] w1,
                                     input logic [15:0] w2);
        begin_test;
        memory[8'hC0] = w0;
        memory[8'hC1] = w1;
        memory[8'hC2] = w2;
        emit_operand_loads;
        emit_word(enc_reg({1'b0, cpu_isa_pkg::ALU_ADD}, 3'd3, 3'd1, 3'd2));
        emit_word(enc_imm(cpu_isa_pkg::OP_STORE, 3'd3, 3'd5, 4'd0));
        emit_word(enc_imm(cpu_isa_pkg::OP_LOAD, 3'd1, 3'd7, 4'd2));
        emit_word(enc_reg({1'b0, cpu_isa_pkg::ALU_SUB}, 3'd3, 3'd3, 3'd1));
        emit_word(enc_imm(cpu_isa_pkg::OP_STORE, 3'd3, 3'd5, 4'd1));
        emit_word(enc_reg({1'b0, cpu_isa_pkg::ALU_XOR}, 3'd3, 3'd3, 3'd2));
        emit_word(enc_imm(cpu_isa_pkg::OP_STORE, 3'd3, 3'd5, 4'd2));
        emit_word(enc_imm({1'b0, cpu_isa_pkg::ALU_LSL}, 3'd3, 3'd3, 4'd3));
        emit_word(enc_imm(cpu_isa_pkg::OP_STORE, 3'd3, 3'd5, 4'd3));
        emit_end;
    endtask

    // two halt windows, both well before the program ends
    task automatic pulse_halt;
        wait (!rst);
        repeat (9) @(negedge clk);
        halt = 1'b1;
        repeat (5) @(negedge clk);
        halt = 1'b0;
        repeat (8) @(negedge clk);
        halt = 1'b1;
        repeat (4) @(negedge clk);
        halt = 1'b0;
    endtask

    task automatic test_halt;
        logic [15:0] w [3];
        logic [15:0] exp_data [4];
        for (int i = 0; i < 3; i++) begin
            w[i] = 16'($random(seed));
        end
        // add, sub, xor and shift by three, each result stored
        exp_data[0] = w[0] + w[1];
        exp_data[1] = exp_data[0] - w[2];
        exp_data[2] = exp_data[1] ^ w[1];
        exp_data[3] = exp_data[2] << 3;
        // same program without halt
        emit_halt_program(w[0], w[1], w[2]);
        run_program;
        for (int k = 0; k < 4; k++) begin
            expect_store($sformatf("plain run result %0d", k), 16'hD0 + 16'(k), exp_data[k]);
        end
        emit_halt_program(w[0], w[1], w[2]);
        fork
            run_program;
            pulse_halt;
        join
        for (int k = 0; k < 4; k++) begin
            expect_store($sformatf("halted run result %0d", k), 16'hD0 + 16'(k), exp_data[k]);
        end
    endtask

    task automatic test_dropped;
        logic [15:0] a;
        logic [15:0] b;
        a = 16'($random(seed));
        b = 16'($random(seed));
        begin_test;
        memory[8'hC0] = a;
        memory[8'hC1] = b;
        emit_operand_loads;
        emit_word(enc_reg({1'b0, cpu_isa_pkg::ALU_SUB}, 3'd3, 3'd1, 3'd2));
        // reserved alu code, mode 11 alu, push, long branch, mode 11 load
        emit_word({5'b01000, 3'd3, 3'd1, 2'b10, 3'd2});
        emit_word({5'b00000, 3'd3, 3'd1, 2'b11, 3'd2});
        emit_word({5'b01110, 3'd3, 3'd1, 2'b00, 3'd0});
        emit_word(16'hF8FF);
        emit_word({cpu_isa_pkg::OP_LOAD, 3'd3, 3'd7, 2'b11, 3'd0});
        emit_word(enc_imm(cpu_isa_pkg::OP_STORE, 3'd3, 3'd7, 4'd4));
        emit_probe;
        emit_end;
        run_program;
        expect_store("r3 after dropped encodings", 16'hC4, a - b);
        check_probe(a, b);
    endtask

    initial begin
        #(TEST_COUNT * CYCLES_PER_TEST * CLK_PERIOD);
        $display("timeout: the tests did not reach their end marker in time");
        $display("Test failed");
        $finish;
    end

    initial begin
        rst        = 1'b1;
        halt       = 1'b0;
        rdata      = '0;
        rd_addr    = '0;
        done       = 1'b0;
        first_seen = 1'b0;
        first_addr = '0;
        halt_seen  = 1'b0;
        halt_addr  = '0;
        errors     = 0;
        seed       = 32'h01963265;
        test_alu;
        test_branches;
        test_load_store;
        test_halt;
        test_dropped;
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
